// ==== sources.f ====
+incdir+verilog
+incdir+sim
verilog/mvu_pkg.sv
verilog/mvu_cfg_decode.sv
verilog/mvu_bitserial_exec.sv
verilog/mvu_quant_result.sv
verilog/mvu_top.sv
sim/mvu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds mvu_tb with Verilator, runs it and searches the log for the pass message

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module mvu_tb --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmvu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification passed" "$LOG"; then
    exit 0
fi
exit 1

// ==== sim/mvu_tb_tasks.svh ====
// AXI4-Lite master tasks, random numbers and value checks for mvu_tb
// Every bus task starts and ends 1 ns after a rising edge
`ifndef MVU_TB_TASKS_SVH
`define MVU_TB_TASKS_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [31:0] rand_next();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
endtask

task automatic axi_write(input logic [`MVU_AXI_AW-1:0] addr, input logic [31:0] data,
                         output logic [1:0] resp);
    int delay;
    delay   = int'(rand_next() % (max_delay + 1));
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge intf);
    while (!awready)
        @(negedge intf);
    check_value("wready", wready, 1'b1);    // Raised together with awready
    @(posedge intf);                 // Address and data taken here
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge intf);
    while (!bvalid)
        @(negedge intf);
    resp = bresp;
    // Response must hold while bready stays low
    repeat (delay) begin
        @(negedge intf);
        check_value("bvalid", bvalid, 1'b1);
        check_value("bresp", bresp, resp);
    end
    @(posedge intf);
    #1;
    bready = 1'b1;
    @(posedge intf);
    #1;
    bready = 1'b0;
endtask

task automatic axi_read(input logic [`MVU_AXI_AW-1:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
    int delay;
    delay   = int'(rand_next() % (max_delay + 1));
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge intf);
    while (!arready)
        @(negedge intf);
    @(posedge intf);
    #1;
    arvalid = 1'b0;
    @(negedge intf);
    while (!rvalid)
        @(negedge intf);
    data = rdata;
    resp = rresp;
    repeat (delay) begin
        @(negedge intf);
        check_value("rvalid", rvalid, 1'b1);
        check_value("rdata", rdata, data);
        check_value("rresp", rresp, resp);
    end
    @(posedge intf);
    #1;
    rready = 1'b1;
    @(posedge intf);
    #1;
    rready = 1'b0;
endtask

`endif

// ==== sim/mvu_tb.sv ====
// Random job testbench for the vector MAC unit with a reference model of the dot product
// Talks to mvu_top only through its AXI4-Lite port
`timescale 1ns/1ns
`include "mvu_settings.svh"

module mvu_tb;

    localparam int NUM_JOBS       = 40;
    localparam int CYCLES_PER_JOB = 4200;    // Longest job plus AXI traffic
    localparam int CYCLE_LIMIT    = NUM_JOBS * CYCLES_PER_JOB + 2000;

    logic                   intf;
    logic                   rst_n;
    logic [`MVU_AXI_AW-1:0] awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [`MVU_AXI_DW-1:0] wdata;
    logic                   wvalid;
    logic                   wready;
    logic                   bvalid;
    logic                   bready;
    logic [1:0]             bresp;
    logic [`MVU_AXI_AW-1:0] araddr;
    logic                   arvalid;
    logic                   arready;
    logic                   rvalid;
    logic                   rready;
    logic [`MVU_AXI_DW-1:0] rdata;
    logic [1:0]             rresp;

    int                     errors;
    int                     checks;
    int                     cycles;
    int                     max_delay;     // Upper bound of bready/rready stalls
    logic [31:0]            rng_state;
    mvu_pkg::vec_word_t     buf_model [`MVU_BUF_DEPTH];

    mvu_top dut0 (
        .intf    (intf),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    `include "mvu_tb_tasks.svh"

    initial begin
        intf = 1'b0;
        forever #5 intf = ~intf;
    end

    // Watchdog
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge intf);
            cycles++;
        end
        errors++;
        $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Verification failed");
        $finish;
    end

    // Two's complement value of the low prec+1 bits
    function automatic longint operand_value(input logic [15:0] raw, input logic [3:0] prec,
                                             input logic is_signed);
        longint v;
        v = longint'(raw) & ((longint'(1) << (prec + 1)) - 1);
        if (is_signed && raw[prec])
            v -= longint'(1) << (prec + 1);
        return v;
    endfunction

    function automatic logic [31:0] expected_result(input mvu_pkg::job_cfg_t cfg,
                                                    input logic [7:0] scaler);
        longint      dot;
        longint      scaled;
        logic [31:0] q;
        int          src;
        dot = 0;
        for (int e = 0; e <= cfg.len; e++) begin
            dot += operand_value(buf_model[cfg.base + e].wgt, cfg.wprec, cfg.w_signed) *
                   operand_value(buf_model[cfg.base + e].inp, cfg.iprec, cfg.i_signed);
        end
        scaled = dot * longint'(scaler);
        q = '0;
        for (int k = 0; k <= cfg.oprec; k++) begin
            src = int'(cfg.quant_msbidx) - int'(cfg.oprec) + k;
            if (src >= 0)
                q[k] = scaled[src];    // Upper longint bits already carry the sign
        end
        return q;
    endfunction

    task automatic run_job(input bit signed_ops, input bit write_while_busy);
        mvu_pkg::job_cfg_t cfg;
        logic [7:0]        scaler;
        logic [31:0]       expected;
        logic [31:0]       data;
        logic [1:0]        resp;
        cfg = mvu_pkg::job_cfg_t'(rand_next());
        cfg.spare = '0;
        cfg.len = 4'(rand_next() % (16 - cfg.base));   // Stay inside the buffer
        if (!signed_ops) begin
            cfg.i_signed = 1'b0;
            cfg.w_signed = 1'b0;
        end
        if (write_while_busy) begin
            // Longest job so the writes below land while busy
            cfg.iprec = 4'hf;
            cfg.wprec = 4'hf;
            cfg.base  = '0;
            cfg.len   = 4'hf;
        end
        scaler = 8'(rand_next());
        for (int e = 0; e < `MVU_BUF_DEPTH; e++) begin
            buf_model[e] = mvu_pkg::vec_word_t'(rand_next());
            axi_write(`MVU_BUF_BASE + 8'(4 * e), buf_model[e], resp);
            check_value("bresp", resp, 2'b00);
        end
        axi_write(`MVU_REG_CFG, cfg, resp);
        check_value("bresp", resp, 2'b00);
        axi_write(`MVU_REG_SCALER, 32'(scaler), resp);
        check_value("bresp", resp, 2'b00);
        expected = expected_result(cfg, scaler);
        axi_write(`MVU_REG_CTRL, 32'h1, resp);
        check_value("bresp", resp, 2'b00);
        if (write_while_busy) begin
            axi_write(`MVU_REG_CFG, rand_next(), resp);
            check_value("bresp", resp, 2'b10);
            axi_write(`MVU_BUF_BASE, rand_next(), resp);
            check_value("bresp", resp, 2'b10);
            axi_write(`MVU_REG_CTRL, 32'h1, resp);
            check_value("bresp", resp, 2'b10);
        end
        data = 32'h1;
        while (data[0])
            axi_read(`MVU_REG_STATUS, data, resp);
        check_value("status", data, 32'h2);      // Idle with irq up
        axi_read(`MVU_REG_STATUS, data, resp);
        check_value("status", data, 32'h2);      // irq is sticky
        axi_read(`MVU_REG_RESULT, data, resp);
        check_value("rresp", resp, 2'b00);
        check_value("result", data, expected);
        axi_write(`MVU_REG_STATUS, 32'h2, resp);
        check_value("bresp", resp, 2'b00);
        axi_read(`MVU_REG_STATUS, data, resp);
        check_value("status", data, 32'h0);
    endtask

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        rst_n     = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        errors    = 0;
        checks    = 0;
        max_delay = 0;
        rng_state = 32'h63cf_44ea;
        repeat (10) @(posedge intf);
        #1;
        rst_n = 1'b1;
        @(posedge intf);
        #1;

        axi_read(`MVU_REG_STATUS, data, resp);
        check_value("status", data, 32'h0);
        check_value("rresp", resp, 2'b00);
        axi_read(`MVU_REG_RESULT, data, resp);
        check_value("result", data, 32'h0);
        check_value("rresp", resp, 2'b00);
        axi_read(8'h20, data, resp);             // Hole in the map
        check_value("rdata", data, 32'h0);
        check_value("rresp", resp, 2'b10);
        axi_write(8'h24, 32'hffff_ffff, resp);
        check_value("bresp", resp, 2'b10);

        for (int j = 0; j < NUM_JOBS / 2; j++)
            run_job(1'b0, 1'b0);
        max_delay = 4;                           // Back-pressure from here on
        for (int j = 0; j < NUM_JOBS / 2 - 1; j++)
            run_job(1'b1, 1'b0);
        run_job(1'b1, 1'b1);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== verilog/mvu_top.sv ====
// Vector MAC unit top level with its AXI4-Lite control port
// No wstrb input since only full-word writes are supported
`timescale 1ns/1ns
`include "mvu_settings.svh"

module mvu_top (
    input  logic                   intf,
    input  logic                   rst_n,
    input  logic [`MVU_AXI_AW-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`MVU_AXI_DW-1:0] wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic                   bvalid,
    input  logic                   bready,
    output logic [1:0]             bresp,
    input  logic [`MVU_AXI_AW-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [`MVU_AXI_DW-1:0] rdata,
    output logic [1:0]             rresp
);

    logic                   start;
    mvu_pkg::job_t          job;
    mvu_pkg::vec_word_t     buf_word;
    logic [`MVU_BUF_AW-1:0] buf_addr;
    logic                   acc_valid;
    mvu_pkg::acc_t          sum;
    logic                   res_valid;
    logic [`MVU_AXI_DW-1:0] res_data;

    mvu_cfg_decode decode0 (
        .intf      (intf),
        .rst_n     (rst_n),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .start     (start),
        .job       (job),
        .buf_word  (buf_word),
        .buf_addr  (buf_addr),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

    mvu_bitserial_exec exec0 (
        .intf      (intf),
        .rst_n     (rst_n),
        .start     (start),
        .job       (job),
        .buf_word  (buf_word),
        .buf_addr  (buf_addr),
        .acc_valid (acc_valid),
        .sum       (sum)
    );

    mvu_quant_result result0 (
        .intf      (intf),
        .rst_n     (rst_n),
        .acc_valid (acc_valid),
        .sum       (sum),
        .job       (job),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

endmodule

// ==== verilog/mvu_quant_result.sv ====
// Two-stage scale and quantize with res_valid two cycles after acc_valid
// Truncating quantizer with no saturation or rounding
`timescale 1ns/1ns
`include "mvu_settings.svh"

module mvu_quant_result (
    input  logic                   intf,
    input  logic                   rst_n,
    input  logic                   acc_valid,
    input  mvu_pkg::acc_t          sum,
    input  mvu_pkg::job_t          job,
    output logic                   res_valid,
    output logic [`MVU_AXI_DW-1:0] res_data
);

    logic                          mul_valid;
    logic signed [`MVU_PROD_W-1:0] sum_ext;
    logic signed [`MVU_PROD_W-1:0] scaler_ext;
    logic signed [`MVU_PROD_W-1:0] prod;
    logic [`MVU_OPW-1:0]           qbits;

    assign sum_ext    = `MVU_PROD_W'(sum);    // Sign extends
    assign scaler_ext = $signed({{(`MVU_PROD_W - `MVU_SCALER_W){1'b0}}, job.scaler});

    // Keep oprec+1 bits ending at quant_msbidx
    always_comb begin
        int src;
        qbits = '0;
        for (int k = 0; k < `MVU_OPW; k++) begin
            src = int'(job.cfg.quant_msbidx) - int'(job.cfg.oprec) + k;
            if (k <= int'(job.cfg.oprec)) begin
                if (src >= `MVU_PROD_W)
                    qbits[k] = prod[`MVU_PROD_W-1];   // Above the product reads as sign
                else if (src >= 0)
                    qbits[k] = prod[src];
            end
        end
    end

    always_ff @(posedge intf or negedge rst_n) begin
        if (!rst_n) begin
            mul_valid <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            mul_valid <= acc_valid;
            res_valid <= mul_valid;
        end
    end

    always_ff @(posedge intf) begin
        if (acc_valid)
            prod <= sum_ext * scaler_ext;     // Fits since scaler is below 256
        if (mul_valid)
            res_data <= `MVU_AXI_DW'(qbits);
    end

endmodule

// ==== verilog/mvu_bitserial_exec.sv ====
// Bit-serial dot product over buffer entries base to base+len
// base+len must stay inside the buffer since the entry address wraps at the end
`timescale 1ns/1ns
`include "mvu_settings.svh"

module mvu_bitserial_exec (
    input  logic                   intf,
    input  logic                   rst_n,
    input  logic                   start,
    input  mvu_pkg::job_t          job,
    input  mvu_pkg::vec_word_t     buf_word,
    output logic [`MVU_BUF_AW-1:0] buf_addr,
    output logic                   acc_valid,
    output mvu_pkg::acc_t          sum
);

    // Issue stage
    logic                   run;
    logic [`MVU_BUF_AW-1:0] elem;
    logic [`MVU_PREC_W-1:0] wb;
    logic [`MVU_PREC_W-1:0] ib;
    logic                   last_pair;

    // Accumulate stage aligned with buf_word
    logic                   p1_valid;
    logic                   p1_last;
    logic [`MVU_PREC_W-1:0] p1_wb;
    logic [`MVU_PREC_W-1:0] p1_ib;
    logic                   p1_neg;
    logic                   bit_and;
    logic [`MVU_PREC_W:0]   shamt;
    mvu_pkg::acc_t          term;
    mvu_pkg::acc_t          acc;

    assign buf_addr  = job.cfg.base + elem;
    assign last_pair = (wb == job.cfg.wprec) && (ib == job.cfg.iprec);

    always_ff @(posedge intf or negedge rst_n) begin
        if (!rst_n) begin
            run       <= 1'b0;
            elem      <= '0;
            wb        <= '0;
            ib        <= '0;
            p1_valid  <= 1'b0;
            p1_last   <= 1'b0;
            p1_wb     <= '0;
            p1_ib     <= '0;
            acc_valid <= 1'b0;
        end else begin
            if (start) begin
                run  <= 1'b1;
                elem <= '0;
                wb   <= '0;
                ib   <= '0;
            end else if (run) begin
                // Input bit is the inner loop
                if (ib != job.cfg.iprec) begin
                    ib <= ib + 1'b1;
                end else begin
                    ib <= '0;
                    if (wb != job.cfg.wprec) begin
                        wb <= wb + 1'b1;
                    end else begin
                        wb   <= '0;
                        elem <= elem + 1'b1;
                        if (elem == job.cfg.len)
                            run <= 1'b0;
                    end
                end
            end
            p1_valid  <= run;
            p1_wb     <= wb;
            p1_ib     <= ib;
            p1_last   <= run && last_pair && (elem == job.cfg.len);
            acc_valid <= p1_valid && p1_last;     // Sum is final on this cycle
        end
    end

    assign bit_and = buf_word.wgt[p1_wb] & buf_word.inp[p1_ib];
    assign shamt   = {1'b0, p1_wb} + {1'b0, p1_ib};
    assign term    = mvu_pkg::acc_t'(bit_and) << shamt;

    // MSB plane of a signed operand weighs negative
    assign p1_neg = (job.cfg.w_signed && p1_wb == job.cfg.wprec) ^
                    (job.cfg.i_signed && p1_ib == job.cfg.iprec);

    always_ff @(posedge intf) begin
        if (start)
            acc <= '0;
        else if (p1_valid)
            acc <= p1_neg ? acc - term : acc + term;
    end

    assign sum = acc;

    a_elem_range: assert property (@(posedge intf) disable iff (!rst_n)
        run |-> ({1'b0, job.cfg.base} + {1'b0, elem}) < `MVU_BUF_DEPTH);
    a_acc_pulse: assert property (@(posedge intf) disable iff (!rst_n)
        acc_valid |=> !acc_valid);

endmodule

// ==== verilog/mvu_cfg_decode.sv ====
// AXI4-Lite slave with vector buffer, job registers and busy/irq status
// wstrb is not supported so every write replaces a whole word
`timescale 1ns/1ns
`include "mvu_settings.svh"

module mvu_cfg_decode (
    input  logic                     intf,
    input  logic                     rst_n,
    // AXI4-Lite slave
    input  logic [`MVU_AXI_AW-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`MVU_AXI_DW-1:0]   wdata,
    input  logic                     wvalid,
    output logic                     wready,
    output logic                     bvalid,
    input  logic                     bready,
    output logic [1:0]               bresp,
    input  logic [`MVU_AXI_AW-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic                     rvalid,
    input  logic                     rready,
    output logic [`MVU_AXI_DW-1:0]   rdata,
    output logic [1:0]               rresp,
    // Datapath side
    output logic                     start,
    output mvu_pkg::job_t            job,
    output mvu_pkg::vec_word_t       buf_word,
    input  logic [`MVU_BUF_AW-1:0]   buf_addr,
    input  logic                     res_valid,
    input  logic [`MVU_AXI_DW-1:0]   res_data
);

    mvu_pkg::vec_word_t       buf_mem [`MVU_BUF_DEPTH];
    mvu_pkg::job_cfg_t        cfg_q;
    logic [`MVU_SCALER_W-1:0] scaler_q;
    logic [`MVU_AXI_DW-1:0]   result_q;
    logic                     busy;
    logic                     irq;

    mvu_pkg::wdata_u          wd;
    logic                     wr_acc;
    logic                     wr_ok;
    logic                     wr_err;
    logic                     wr_is_buf;
    logic                     start_wr;
    logic                     ar_acc;
    logic                     rd_err;
    logic                     rd_is_buf;
    logic [`MVU_AXI_DW-1:0]   rd_val;

    assign wd.raw = wdata;

    // One write in flight at a time
    assign wr_acc  = awvalid && wvalid && !bvalid;
    assign awready = wr_acc;
    assign wready  = wr_acc;
    assign ar_acc  = arvalid && !rvalid;
    assign arready = !rvalid;

    assign wr_is_buf = (awaddr >= `MVU_BUF_BASE) &&
                       (awaddr < `MVU_BUF_BASE + 4 * `MVU_BUF_DEPTH);
    assign rd_is_buf = (araddr >= `MVU_BUF_BASE) &&
                       (araddr < `MVU_BUF_BASE + 4 * `MVU_BUF_DEPTH);

    always_comb begin
        case (awaddr)
            `MVU_REG_CTRL, `MVU_REG_CFG, `MVU_REG_SCALER: wr_err = busy;
            `MVU_REG_STATUS, `MVU_REG_RESULT:             wr_err = 1'b0;
            default:                                      wr_err = !wr_is_buf || busy;
        endcase
    end

    assign wr_ok    = wr_acc && !wr_err;
    assign start_wr = wr_ok && (awaddr == `MVU_REG_CTRL) && wd.raw[0];

    // Read mux returning zero on errors
    always_comb begin
        rd_err = 1'b0;
        rd_val = '0;
        case (araddr)
            `MVU_REG_CTRL:   rd_val = '0;
            `MVU_REG_CFG:    rd_val = cfg_q;
            `MVU_REG_SCALER: rd_val = `MVU_AXI_DW'(scaler_q);
            `MVU_REG_STATUS: rd_val = {30'b0, irq, busy};
            `MVU_REG_RESULT: rd_val = result_q;
            default: begin
                if (rd_is_buf)
                    rd_val = buf_mem[araddr[`MVU_BUF_AW+1:2]];
                else
                    rd_err = 1'b1;
            end
        endcase
    end

    // Buffer RAM with registered datapath read
    always_ff @(posedge intf) begin
        if (wr_ok && wr_is_buf)
            buf_mem[awaddr[`MVU_BUF_AW+1:2]] <= wd.vec;
        buf_word <= buf_mem[buf_addr];
    end

    always_ff @(posedge intf or negedge rst_n) begin
        if (!rst_n) begin
            bvalid   <= 1'b0;
            bresp    <= 2'b00;
            rvalid   <= 1'b0;
            rresp    <= 2'b00;
            rdata    <= '0;
            start    <= 1'b0;
            busy     <= 1'b0;
            irq      <= 1'b0;
            result_q <= '0;
            cfg_q    <= '0;
            scaler_q <= '0;
        end else begin
            start <= start_wr;

            if (wr_acc) begin
                bvalid <= 1'b1;
                bresp  <= wr_err ? 2'b10 : 2'b00;   // SLVERR or OKAY
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            if (ar_acc) begin
                rvalid <= 1'b1;
                rdata  <= rd_val;
                rresp  <= rd_err ? 2'b10 : 2'b00;
            end else if (rready) begin
                rvalid <= 1'b0;
            end

            if (wr_ok && awaddr == `MVU_REG_CFG)
                cfg_q <= wd.cfg;
            if (wr_ok && awaddr == `MVU_REG_SCALER)
                scaler_q <= wd.raw[`MVU_SCALER_W-1:0];

            if (start_wr)
                busy <= 1'b1;
            else if (res_valid)
                busy <= 1'b0;

            // Setting wins over a clear in the same cycle
            if (res_valid) begin
                result_q <= res_data;
                irq      <= 1'b1;
            end else if (wr_ok && awaddr == `MVU_REG_STATUS && wd.raw[1]) begin
                irq <= 1'b0;
            end
        end
    end

    assign job.cfg    = cfg_q;
    assign job.scaler = scaler_q;

    a_bvalid_hold: assert property (@(posedge intf) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));
    a_rvalid_hold: assert property (@(posedge intf) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));
    a_start_idle: assert property (@(posedge intf) disable iff (!rst_n)
        start |-> !$past(busy));

endmodule

// ==== verilog/mvu_pkg.sv ====
// Shared types of the vector MAC unit
// Field widths come from the macros in mvu_settings.svh
`include "mvu_settings.svh"

package mvu_pkg;

    // One buffer entry
    typedef struct packed {
        logic [`MVU_OPW-1:0] wgt;   // Weight operand
        logic [`MVU_OPW-1:0] inp;   // Input operand
    } vec_word_t;

    // Job configuration word listed MSB first
    typedef struct packed {
        logic [3:0]               spare;
        logic [`MVU_PREC_W-1:0]   iprec;         // Input precision minus one
        logic [`MVU_PREC_W-1:0]   wprec;         // Weight precision minus one
        logic [`MVU_PREC_W-1:0]   oprec;         // Output precision minus one
        logic [`MVU_MSBIDX_W-1:0] quant_msbidx;  // Top bit kept by the quantizer
        logic [`MVU_BUF_AW-1:0]   base;          // First buffer entry
        logic [`MVU_BUF_AW-1:0]   len;           // Element count minus one
        logic                     i_signed;
        logic                     w_signed;
    } job_cfg_t;

    // A write-data word seen as a buffer entry or as a job config
    typedef union packed {
        logic [`MVU_AXI_DW-1:0] raw;
        vec_word_t              vec;
        job_cfg_t               cfg;
    } wdata_u;

    typedef logic signed [`MVU_ACC_W-1:0] acc_t;

    // Everything the datapath needs for one job
    typedef struct packed {
        job_cfg_t                 cfg;
        logic [`MVU_SCALER_W-1:0] scaler;
    } job_t;

endpackage

// ==== verilog/mvu_settings.svh ====
// Widths, buffer depth and AXI4-Lite address map of the vector MAC unit
// Register offsets are byte addresses and every access is one full 32-bit word
`ifndef MVU_SETTINGS_SVH
`define MVU_SETTINGS_SVH

// AXI4-Lite port
`define MVU_AXI_AW      8
`define MVU_AXI_DW      32

// Datapath
`define MVU_OPW         16      // Operand width per half word
`define MVU_PREC_W      4       // Precision fields hold length minus one
`define MVU_BUF_DEPTH   16
`define MVU_BUF_AW      4
`define MVU_SCALER_W    8
`define MVU_ACC_W       37      // 16 signed 32-bit products
`define MVU_PROD_W      45      // Accumulator times unsigned scaler
`define MVU_MSBIDX_W    6

// Register map
`define MVU_REG_CTRL    8'h00
`define MVU_REG_CFG     8'h04
`define MVU_REG_SCALER  8'h08
`define MVU_REG_STATUS  8'h0C
`define MVU_REG_RESULT  8'h10
`define MVU_BUF_BASE    8'h40   // One word per entry up to 0x7C

`endif
